// ==== simf_alu_pkg.sv ====
package simf_alu_pkg;

   localparam int DATA_W   = 32;
   localparam int EXP_W    = 8;
   localparam int MAN_W    = 23;
   localparam int EXP_BIAS = 127;

   // Encoding format, control bits 31:24
   localparam logic [7:0] FMT_VOP2  = 8'h40;
   localparam logic [7:0] FMT_VOPC  = 8'h20;
   localparam logic [7:0] FMT_VOP3A = 8'h10;

   localparam logic [11:0] OPC_ADD      = 12'h003;
   localparam logic [11:0] OPC_SUB      = 12'h004;
   localparam logic [11:0] OPC_SUBREV   = 12'h005;
   localparam logic [11:0] OPC_MUL      = 12'h008;
   localparam logic [11:0] OPC_VOP3_OFS = 12'h100;  // VOP3A arith = VOP2 + 0x100
   localparam logic [11:0] OPC_CMP_BASE = 12'h000;  // Low nibble is the condition

   typedef enum logic [2:0] {
      OP_NONE,
      OP_ADD,
      OP_SUB,
      OP_SUBREV,
      OP_MUL,
      OP_CMP
   } alu_op_e;

   typedef enum logic [3:0] {
      CMP_F,
      CMP_LT,
      CMP_EQ,
      CMP_LE,
      CMP_GT,
      CMP_LG,
      CMP_GE,
      CMP_O,    // Always true without NaN
      CMP_U,    // Always false without NaN
      CMP_NGE,
      CMP_NLG,
      CMP_NGT,
      CMP_NLE,
      CMP_NEQ,
      CMP_NLT,
      CMP_TRU
   } cmp_cond_e;

endpackage

// ==== simf_decode.sv ====
`timescale 1ns/1ps
module simf_decode
  (
   input  logic [simf_alu_pkg::DATA_W-1:0] alu_control_i,
   input  logic                            exec_i,
   output simf_alu_pkg::alu_op_e           op_o,
   output simf_alu_pkg::cmp_cond_e         cond_o
   );

   logic [7:0]  fmt;
   logic [11:0] opc;
   logic [11:0] opc_vop3;
   logic        cmp_code;
   logic        cmp_fmt;

   assign fmt      = alu_control_i[31:24];
   assign opc      = alu_control_i[11:0];
   assign opc_vop3 = opc - simf_alu_pkg::OPC_VOP3_OFS;  // Fold into VOP2 range
   assign cmp_code = (opc[11:4] == simf_alu_pkg::OPC_CMP_BASE[11:4]);
   assign cmp_fmt  = (fmt == simf_alu_pkg::FMT_VOPC) || (fmt == simf_alu_pkg::FMT_VOP3A);

   function automatic simf_alu_pkg::alu_op_e arith_op(input logic [11:0] code);
      simf_alu_pkg::alu_op_e op;
      case (code)
         simf_alu_pkg::OPC_ADD    : op = simf_alu_pkg::OP_ADD;
         simf_alu_pkg::OPC_SUB    : op = simf_alu_pkg::OP_SUB;
         simf_alu_pkg::OPC_SUBREV : op = simf_alu_pkg::OP_SUBREV;
         simf_alu_pkg::OPC_MUL    : op = simf_alu_pkg::OP_MUL;
         default                  : op = simf_alu_pkg::OP_NONE;
      endcase
      return op;
   endfunction

   always_comb
   begin
      op_o   = simf_alu_pkg::OP_NONE;
      cond_o = simf_alu_pkg::CMP_F;
      if (exec_i)  // Disabled lane stays OP_NONE
      begin
         if (cmp_fmt && cmp_code)
         begin
            op_o   = simf_alu_pkg::OP_CMP;
            cond_o = simf_alu_pkg::cmp_cond_e'(opc[3:0]);
         end
         else if (fmt == simf_alu_pkg::FMT_VOP2)
            op_o = arith_op(opc);
         else if (fmt == simf_alu_pkg::FMT_VOP3A)
            op_o = arith_op(opc_vop3);
      end
   end

endmodule

// ==== simf_fp_arith.sv ====
`timescale 1ns/1ps
module simf_fp_arith
  (
   input  logic                            clk,
   input  logic                            rst_n_i,
   input  logic                            start_i,
   input  simf_alu_pkg::alu_op_e           op_i,
   input  logic [simf_alu_pkg::DATA_W-1:0] src_a_i,
   input  logic [simf_alu_pkg::DATA_W-1:0] src_b_i,
   output logic [simf_alu_pkg::DATA_W-1:0] result_o,
   output logic                            done_o
   );

   typedef enum logic [2:0] {ST_IDLE, ST_ALIGN, ST_ADD, ST_NORM, ST_PACK} state_e;

   state_e                                  state_q;
   logic [simf_alu_pkg::DATA_W-1:0]         a_q;
   logic [simf_alu_pkg::DATA_W-1:0]         b_q;
   logic                                    mul_q;
   logic                                    sub_q;
   logic                                    sign_q;
   logic [simf_alu_pkg::MAN_W:0]            big_q;
   logic [simf_alu_pkg::MAN_W:0]            small_q;
   logic [simf_alu_pkg::MAN_W+1:0]          man_q;    // Binary point below bit 23
   logic signed [simf_alu_pkg::EXP_W+1:0]   exp_q;

   logic                                    arith_start;
   logic                                    is_sub;
   logic [simf_alu_pkg::DATA_W-1:0]         src_a;
   logic [simf_alu_pkg::DATA_W-1:0]         src_b;
   logic [simf_alu_pkg::EXP_W-1:0]          exp_a;
   logic [simf_alu_pkg::EXP_W-1:0]          exp_b;
   logic [simf_alu_pkg::MAN_W:0]            man_a;
   logic [simf_alu_pkg::MAN_W:0]            man_b;
   logic                                    a_ge_b;
   logic [2*simf_alu_pkg::MAN_W+1:0]        product;
   logic signed [simf_alu_pkg::EXP_W+1:0]   exp_mul;

   assign arith_start = start_i && (op_i inside {simf_alu_pkg::OP_ADD, simf_alu_pkg::OP_SUB,
                                                 simf_alu_pkg::OP_SUBREV, simf_alu_pkg::OP_MUL});
   assign is_sub = (op_i == simf_alu_pkg::OP_SUB) || (op_i == simf_alu_pkg::OP_SUBREV);
   assign src_a  = (op_i == simf_alu_pkg::OP_SUBREV) ? src_b_i : src_a_i;
   assign src_b  = (op_i == simf_alu_pkg::OP_SUBREV) ? src_a_i : src_b_i;

   assign exp_a   = a_q[simf_alu_pkg::DATA_W-2 -: simf_alu_pkg::EXP_W];
   assign exp_b   = b_q[simf_alu_pkg::DATA_W-2 -: simf_alu_pkg::EXP_W];
   assign man_a   = (exp_a == '0) ? '0 : {1'b1, a_q[simf_alu_pkg::MAN_W-1:0]};  // Zero exp is 0
   assign man_b   = (exp_b == '0) ? '0 : {1'b1, b_q[simf_alu_pkg::MAN_W-1:0]};
   assign a_ge_b  = {exp_a, man_a} >= {exp_b, man_b};
   assign product = man_a * man_b;
   assign exp_mul = {2'b00, exp_a} + {2'b00, exp_b}
                    - simf_alu_pkg::EXP_BIAS[simf_alu_pkg::EXP_W+1:0];

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         state_q <= ST_IDLE;
         done_o  <= 1'b0;
      end
      else
      begin
         done_o <= (state_q == ST_PACK);
         case (state_q)
            ST_IDLE  : if (arith_start) state_q <= ST_ALIGN;
            ST_ALIGN : state_q <= ST_ADD;
            ST_ADD   : state_q <= ST_NORM;
            ST_NORM  : if (man_q == '0 || man_q[simf_alu_pkg::MAN_W+1:simf_alu_pkg::MAN_W] == 2'b01)
                          state_q <= ST_PACK;
            default  : state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      case (state_q)
         ST_IDLE :
            if (arith_start)
            begin
               a_q   <= src_a;
               b_q   <= {src_b[simf_alu_pkg::DATA_W-1] ^ is_sub, src_b[simf_alu_pkg::DATA_W-2:0]};
               mul_q <= (op_i == simf_alu_pkg::OP_MUL);
            end
         ST_ALIGN :
         begin
            sub_q <= a_q[simf_alu_pkg::DATA_W-1] ^ b_q[simf_alu_pkg::DATA_W-1];
            if (mul_q)
            begin
               man_q  <= product[2*simf_alu_pkg::MAN_W+1 -: simf_alu_pkg::MAN_W+2];  // Truncate
               exp_q  <= exp_mul;
               sign_q <= a_q[simf_alu_pkg::DATA_W-1] ^ b_q[simf_alu_pkg::DATA_W-1];
            end
            else if (a_ge_b)
            begin
               big_q   <= man_a;
               small_q <= man_b >> (exp_a - exp_b);  // Shifted-out bits lost
               exp_q   <= {2'b00, exp_a};
               sign_q  <= a_q[simf_alu_pkg::DATA_W-1];
            end
            else
            begin
               big_q   <= man_b;
               small_q <= man_a >> (exp_b - exp_a);
               exp_q   <= {2'b00, exp_b};
               sign_q  <= b_q[simf_alu_pkg::DATA_W-1];
            end
         end
         ST_ADD :
            if (!mul_q)
               man_q <= sub_q ? {1'b0, big_q} - {1'b0, small_q} : {1'b0, big_q} + {1'b0, small_q};
         ST_NORM :
            if (man_q[simf_alu_pkg::MAN_W+1])
            begin
               man_q <= man_q >> 1;
               exp_q <= exp_q + 1'b1;
            end
            else if (man_q != '0 && !man_q[simf_alu_pkg::MAN_W])
            begin
               man_q <= man_q << 1;
               exp_q <= exp_q - 1'b1;
            end
         ST_PACK :
            if (man_q == '0 || exp_q <= 0)  // Zero and underflow give +0
               result_o <= '0;
            else if (exp_q[simf_alu_pkg::EXP_W] || &exp_q[simf_alu_pkg::EXP_W-1:0])
               result_o <= {sign_q, {simf_alu_pkg::EXP_W{1'b1}}, {simf_alu_pkg::MAN_W{1'b0}}};
            else
               result_o <= {sign_q, exp_q[simf_alu_pkg::EXP_W-1:0],
                            man_q[simf_alu_pkg::MAN_W-1:0]};
         default : ;
      endcase
   end

endmodule

// ==== simf_fp_compare.sv ====
`timescale 1ns/1ps
module simf_fp_compare
  (
   input  logic                            clk,
   input  logic                            rst_n_i,
   input  logic                            start_i,
   input  simf_alu_pkg::alu_op_e           op_i,
   input  simf_alu_pkg::cmp_cond_e         cond_i,
   input  logic [simf_alu_pkg::DATA_W-1:0] src_a_i,
   input  logic [simf_alu_pkg::DATA_W-1:0] src_b_i,
   output logic                            vcc_o,
   output logic                            done_o
   );

   logic                            zero_a;
   logic                            zero_b;
   logic                            sign_a;
   logic                            sign_b;
   logic [simf_alu_pkg::DATA_W-2:0] mag_a;
   logic [simf_alu_pkg::DATA_W-2:0] mag_b;
   logic                            lt;
   logic                            eq;
   logic                            gt;
   logic                            cmp_start;
   logic                            cmp_bit;

   assign zero_a    = (src_a_i[simf_alu_pkg::DATA_W-2 -: simf_alu_pkg::EXP_W] == '0);
   assign zero_b    = (src_b_i[simf_alu_pkg::DATA_W-2 -: simf_alu_pkg::EXP_W] == '0);
   assign sign_a    = src_a_i[simf_alu_pkg::DATA_W-1] && !zero_a;  // -0 folds to +0
   assign sign_b    = src_b_i[simf_alu_pkg::DATA_W-1] && !zero_b;
   assign mag_a     = zero_a ? '0 : src_a_i[simf_alu_pkg::DATA_W-2:0];
   assign mag_b     = zero_b ? '0 : src_b_i[simf_alu_pkg::DATA_W-2:0];
   assign eq        = (sign_a == sign_b) && (mag_a == mag_b);
   assign lt        = (sign_a != sign_b) ? sign_a : (sign_a ? mag_a > mag_b : mag_a < mag_b);
   assign gt        = !lt && !eq;
   assign cmp_start = start_i && (op_i == simf_alu_pkg::OP_CMP);

   always_comb
   begin
      case (cond_i)
         simf_alu_pkg::CMP_LT, simf_alu_pkg::CMP_NGE  : cmp_bit = lt;
         simf_alu_pkg::CMP_EQ, simf_alu_pkg::CMP_NLG  : cmp_bit = eq;
         simf_alu_pkg::CMP_LE, simf_alu_pkg::CMP_NGT  : cmp_bit = !gt;
         simf_alu_pkg::CMP_GT, simf_alu_pkg::CMP_NLE  : cmp_bit = gt;
         simf_alu_pkg::CMP_LG, simf_alu_pkg::CMP_NEQ  : cmp_bit = !eq;
         simf_alu_pkg::CMP_GE, simf_alu_pkg::CMP_NLT  : cmp_bit = !lt;
         simf_alu_pkg::CMP_O, simf_alu_pkg::CMP_TRU   : cmp_bit = 1'b1;
         default                                      : cmp_bit = 1'b0;  // F and U
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
         done_o <= 1'b0;
      else
         done_o <= cmp_start;
   end

   always_ff @(posedge clk)
   begin
      if (cmp_start)
         vcc_o <= cmp_bit;
   end

endmodule

// ==== simf_writeback.sv ====
`timescale 1ns/1ps
module simf_writeback
  (
   input  logic                            clk,
   input  logic                            rst_n_i,
   input  logic                            start_i,
   input  simf_alu_pkg::alu_op_e           op_i,
   input  logic                            vcc_i,
   input  logic [simf_alu_pkg::DATA_W-1:0] arith_result_i,
   input  logic                            arith_done_i,
   input  logic                            cmp_vcc_i,
   input  logic                            cmp_done_i,
   output logic [simf_alu_pkg::DATA_W-1:0] vgpr_data_o,
   output logic                            vcc_o,
   output logic                            done_o
   );

   simf_alu_pkg::alu_op_e op_q;
   logic                  vcc_q;
   logic                  none_done_q;

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         op_q        <= simf_alu_pkg::OP_NONE;
         vcc_q       <= 1'b0;
         none_done_q <= 1'b0;
      end
      else
      begin
         none_done_q <= start_i && (op_i == simf_alu_pkg::OP_NONE);  // Disabled or unknown
         if (start_i)
         begin
            op_q  <= op_i;
            vcc_q <= vcc_i;
         end
      end
   end

   // Only registered values feed the outputs
   assign done_o = arith_done_i || cmp_done_i || none_done_q;

   always_comb
   begin
      case (op_q)
         simf_alu_pkg::OP_NONE :
         begin
            vgpr_data_o = '0;
            vcc_o       = vcc_q;
         end
         simf_alu_pkg::OP_CMP :
         begin
            vgpr_data_o = '0;
            vcc_o       = cmp_vcc_i;
         end
         default :
         begin
            vgpr_data_o = arith_result_i;
            vcc_o       = vcc_q;  // VCC passes through
         end
      endcase
   end

endmodule

// ==== simf_alu.sv ====
`timescale 1ns/1ps
module simf_alu
  (
   input  logic                            clk,
   input  logic                            rst_n_i,
   input  logic                            alu_start_i,
   input  logic [simf_alu_pkg::DATA_W-1:0] alu_control_i,
   input  logic [simf_alu_pkg::DATA_W-1:0] alu_source1_data_i,
   input  logic [simf_alu_pkg::DATA_W-1:0] alu_source2_data_i,
   input  logic                            alu_source_vcc_value_i,
   input  logic                            alu_source_exec_value_i,
   output logic [simf_alu_pkg::DATA_W-1:0] alu_vgpr_dest_data_o,
   output logic                            alu_dest_vcc_value_o,
   output logic                            alu_done_o
   );

   simf_alu_pkg::alu_op_e           op;
   simf_alu_pkg::cmp_cond_e         cond;
   logic [simf_alu_pkg::DATA_W-1:0] arith_result;
   logic                            arith_done;
   logic                            cmp_vcc;
   logic                            cmp_done;

   simf_decode i_decode
     (
      .alu_control_i (alu_control_i),
      .exec_i        (alu_source_exec_value_i),
      .op_o          (op),
      .cond_o        (cond)
      );

   simf_fp_arith i_arith
     (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .start_i  (alu_start_i),
      .op_i     (op),
      .src_a_i  (alu_source1_data_i),
      .src_b_i  (alu_source2_data_i),
      .result_o (arith_result),
      .done_o   (arith_done)
      );

   simf_fp_compare i_compare
     (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .start_i (alu_start_i),
      .op_i    (op),
      .cond_i  (cond),
      .src_a_i (alu_source1_data_i),
      .src_b_i (alu_source2_data_i),
      .vcc_o   (cmp_vcc),
      .done_o  (cmp_done)
      );

   simf_writeback i_writeback
     (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .start_i        (alu_start_i),
      .op_i           (op),
      .vcc_i          (alu_source_vcc_value_i),
      .arith_result_i (arith_result),
      .arith_done_i   (arith_done),
      .cmp_vcc_i      (cmp_vcc),
      .cmp_done_i     (cmp_done),
      .vgpr_data_o    (alu_vgpr_dest_data_o),
      .vcc_o          (alu_dest_vcc_value_o),
      .done_o         (alu_done_o)
      );

endmodule

// ==== simf_alu_chk.sv ====
`timescale 1ns/1ps
module simf_alu_chk
  (
   input logic                  clk,
   input logic                  rst_n_i,
   input logic                  start_i,
   input logic                  done_i,
   input simf_alu_pkg::alu_op_e op_i
   );

   logic busy_q;
   int   fail_cnt = 0;

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
         busy_q <= 1'b0;
      else if (start_i)
         busy_q <= 1'b1;
      else if (done_i)
         busy_q <= 1'b0;
   end

   no_start_while_busy : assert property (@(posedge clk) disable iff (!rst_n_i)
      start_i |-> !busy_q)
      else
      begin
         $error("start pulsed while an operation is in flight");
         fail_cnt++;
      end

   done_one_cycle : assert property (@(posedge clk) disable iff (!rst_n_i)
      done_i |=> !done_i)
      else
      begin
         $error("done held longer than one cycle");
         fail_cnt++;
      end

   quick_done : assert property (@(posedge clk) disable iff (!rst_n_i)
      start_i && !(op_i inside {simf_alu_pkg::OP_ADD, simf_alu_pkg::OP_SUB,
                                simf_alu_pkg::OP_SUBREV, simf_alu_pkg::OP_MUL}) |=> done_i)
      else
      begin
         $error("done missing one cycle after a non-arithmetic start");
         fail_cnt++;
      end

endmodule

// ==== simf_alu_monitor.sv ====
`timescale 1ns/1ps
module simf_alu_monitor
  (
   input  logic        clk,
   input  logic        rst_n_i,
   input  logic        start_i,
   input  logic [31:0] control_i,
   input  logic [31:0] src1_i,
   input  logic [31:0] src2_i,
   input  logic        vcc_i,
   input  logic        exec_i,
   input  logic        use_model_i,   // Expected values come from the model
   input  logic [31:0] exp_data_i,
   input  logic        exp_vcc_i,
   input  logic [31:0] data_i,
   input  logic        dest_vcc_i,
   input  logic        done_i,
   output int          pass_cnt_o,
   output int          fail_cnt_o
   );

   localparam int MAX_WAIT = 40;

   function automatic simf_alu_pkg::alu_op_e op_class(input logic [31:0] c, input logic exec);
      logic [11:0] base;
      if (!exec)
         return simf_alu_pkg::OP_NONE;
      if ((c[31:24] == simf_alu_pkg::FMT_VOPC || c[31:24] == simf_alu_pkg::FMT_VOP3A)
          && c[11:4] == 8'h00)
         return simf_alu_pkg::OP_CMP;
      if (c[31:24] == simf_alu_pkg::FMT_VOP2)
         base = c[11:0];
      else if (c[31:24] == simf_alu_pkg::FMT_VOP3A)
         base = c[11:0] - simf_alu_pkg::OPC_VOP3_OFS;
      else
         return simf_alu_pkg::OP_NONE;
      case (base)
         simf_alu_pkg::OPC_ADD    : return simf_alu_pkg::OP_ADD;
         simf_alu_pkg::OPC_SUB    : return simf_alu_pkg::OP_SUB;
         simf_alu_pkg::OPC_SUBREV : return simf_alu_pkg::OP_SUBREV;
         simf_alu_pkg::OPC_MUL    : return simf_alu_pkg::OP_MUL;
         default                  : return simf_alu_pkg::OP_NONE;
      endcase
   endfunction

   // Normalize to 1.x and apply flush and saturation
   function automatic logic [31:0] pack_float(input logic sign, input logic [63:0] mag,
                                              input int e);
      logic [63:0] m;
      int          ex;
      m  = mag;
      ex = e;
      if (m == 0)
         return 32'h0;
      while (m >= 64'h100_0000)
      begin
         m = m >> 1;
         ex++;
      end
      while (m < 64'h80_0000)
      begin
         m = m << 1;
         ex--;
      end
      if (ex <= 0)
         return 32'h0;
      if (ex >= 255)
         return {sign, 8'hFF, 23'h0};
      return {sign, ex[7:0], m[22:0]};
   endfunction

   function automatic logic [31:0] model_arith(input simf_alu_pkg::alu_op_e op,
                                               input logic [31:0] a, input logic [31:0] b);
      logic [31:0] x;
      logic [31:0] y;
      logic [63:0] mx;
      logic [63:0] my;
      logic [63:0] s;
      logic        sx;
      logic        sy;
      int          ex;
      int          ey;
      x  = (op == simf_alu_pkg::OP_SUBREV) ? b : a;
      y  = (op == simf_alu_pkg::OP_SUBREV) ? a : b;
      sx = x[31];
      sy = y[31] ^ (op == simf_alu_pkg::OP_SUB || op == simf_alu_pkg::OP_SUBREV);
      ex = x[30:23];
      ey = y[30:23];
      mx = (ex == 0) ? 64'h0 : {40'h0, 1'b1, x[22:0]};
      my = (ey == 0) ? 64'h0 : {40'h0, 1'b1, y[22:0]};
      if (op == simf_alu_pkg::OP_MUL)
         return pack_float(sx ^ sy, (mx * my) >> 23, ex + ey - 127);
      if (ex > ey || (ex == ey && mx >= my))
      begin
         s = my >> (ex - ey);
         return pack_float(sx, (sx == sy) ? mx + s : mx - s, ex);
      end
      s = mx >> (ey - ex);
      return pack_float(sy, (sx == sy) ? my + s : my - s, ey);
   endfunction

   function automatic logic model_cmp(input logic [3:0] cond, input logic [31:0] a,
                                      input logic [31:0] b);
      logic signed [32:0] ka;
      logic signed [32:0] kb;
      logic               lt;
      logic               eq;
      ka = (a[30:23] == 0) ? 33'sd0 : (a[31] ? -$signed({2'b00, a[30:0]})
                                             : $signed({2'b00, a[30:0]}));
      kb = (b[30:23] == 0) ? 33'sd0 : (b[31] ? -$signed({2'b00, b[30:0]})
                                             : $signed({2'b00, b[30:0]}));
      lt = ka < kb;
      eq = ka == kb;
      case (cond)
         simf_alu_pkg::CMP_LT, simf_alu_pkg::CMP_NGE : return lt;
         simf_alu_pkg::CMP_EQ, simf_alu_pkg::CMP_NLG : return eq;
         simf_alu_pkg::CMP_LE, simf_alu_pkg::CMP_NGT : return lt || eq;
         simf_alu_pkg::CMP_GT, simf_alu_pkg::CMP_NLE : return !lt && !eq;
         simf_alu_pkg::CMP_LG, simf_alu_pkg::CMP_NEQ : return !eq;
         simf_alu_pkg::CMP_GE, simf_alu_pkg::CMP_NLT : return !lt;
         simf_alu_pkg::CMP_O, simf_alu_pkg::CMP_TRU  : return 1'b1;
         default                                     : return 1'b0;
      endcase
   endfunction

   initial
   begin
      pass_cnt_o = 0;
      fail_cnt_o = 0;
   end

   always
   begin : watch
      simf_alu_pkg::alu_op_e cls;
      logic [31:0]           want_data;
      logic                  want_vcc;
      int                    cycles;
      int                    n;
      bit                    bad;
      @(posedge clk);
      if (rst_n_i && start_i)
      begin
         n   = pass_cnt_o + fail_cnt_o + 1;
         bad = 0;
         cls = op_class(control_i, exec_i);
         want_data = exp_data_i;
         want_vcc  = exp_vcc_i;
         if (use_model_i)
         begin
            want_data = (cls inside {simf_alu_pkg::OP_NONE, simf_alu_pkg::OP_CMP}) ?
                        32'h0 : model_arith(cls, src1_i, src2_i);
            want_vcc  = (cls == simf_alu_pkg::OP_CMP) ?
                        model_cmp(control_i[3:0], src1_i, src2_i) : vcc_i;
         end
         cycles = 0;
         do
         begin
            @(posedge clk);
            cycles++;
         end
         while (!done_i && cycles < MAX_WAIT);
         if (!done_i)
         begin
            $display("test %0d: no done within %0d cycles of start", n, MAX_WAIT);
            bad = 1;
         end
         else
         begin
            if (cls == simf_alu_pkg::OP_CMP || cls == simf_alu_pkg::OP_NONE)
               if (cycles != 1)
               begin
                  $display("test %0d: done came %0d cycles after start instead of 1",
                           n, cycles);
                  bad = 1;
               end
            if (data_i !== want_data)
            begin
               $display("ERR test %0d alu_vgpr_dest_data_o got %h expected %h",
                        n, data_i, want_data);
               bad = 1;
            end
            if (dest_vcc_i !== want_vcc)
            begin
               $display("ERR test %0d alu_dest_vcc_value_o got %h expected %h",
                        n, dest_vcc_i, want_vcc);
               bad = 1;
            end
         end
         if (bad)
            fail_cnt_o++;
         else
         begin
            $display("test %0d ok", n);
            pass_cnt_o++;
         end
      end
   end

endmodule

// ==== tb_simf_alu.sv ====
`timescale 1ns/1ps
module tb_simf_alu;

   localparam int NUM_TABLE  = 22;
   localparam int NUM_SWEEP  = 48;   // 16 conditions, 3 pairs
   localparam int NUM_RANDOM = 12;
   localparam int NUM_TESTS  = NUM_TABLE + NUM_SWEEP + NUM_RANDOM;
   localparam int TIMEOUT    = NUM_TESTS * 40 + 100;
   localparam logic [31:0] SEED = 32'd80595;

   logic        clk = 1'b0;
   logic        rst_n_i;
   logic        alu_start_i;
   logic [31:0] alu_control_i;
   logic [31:0] alu_source1_data_i;
   logic [31:0] alu_source2_data_i;
   logic        alu_source_vcc_value_i;
   logic        alu_source_exec_value_i;
   logic [31:0] alu_vgpr_dest_data_o;
   logic        alu_dest_vcc_value_o;
   logic        alu_done_o;

   logic        use_model;
   logic [31:0] exp_data;
   logic        exp_vcc;
   int          pass_cnt;
   int          fail_cnt;
   int          cycle_cnt = 0;
   logic [31:0] lfsr;

   logic [7:0]  q_fmt[$];
   logic [11:0] q_opc[$];
   logic [31:0] q_a[$];
   logic [31:0] q_b[$];
   logic        q_exec[$];
   logic        q_vcc[$];
   logic [31:0] q_data[$];
   logic        q_vcc_out[$];

   always #50 clk = ~clk;

   simf_alu i_simf_alu
     (
      .clk                     (clk),
      .rst_n_i                 (rst_n_i),
      .alu_start_i             (alu_start_i),
      .alu_control_i           (alu_control_i),
      .alu_source1_data_i      (alu_source1_data_i),
      .alu_source2_data_i      (alu_source2_data_i),
      .alu_source_vcc_value_i  (alu_source_vcc_value_i),
      .alu_source_exec_value_i (alu_source_exec_value_i),
      .alu_vgpr_dest_data_o    (alu_vgpr_dest_data_o),
      .alu_dest_vcc_value_o    (alu_dest_vcc_value_o),
      .alu_done_o              (alu_done_o)
      );

   simf_alu_monitor i_monitor
     (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .start_i     (alu_start_i),
      .control_i   (alu_control_i),
      .src1_i      (alu_source1_data_i),
      .src2_i      (alu_source2_data_i),
      .vcc_i       (alu_source_vcc_value_i),
      .exec_i      (alu_source_exec_value_i),
      .use_model_i (use_model),
      .exp_data_i  (exp_data),
      .exp_vcc_i   (exp_vcc),
      .data_i      (alu_vgpr_dest_data_o),
      .dest_vcc_i  (alu_dest_vcc_value_o),
      .done_i      (alu_done_o),
      .pass_cnt_o  (pass_cnt),
      .fail_cnt_o  (fail_cnt)
      );

   bind simf_alu simf_alu_chk i_chk
     (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .start_i (alu_start_i),
      .done_i  (alu_done_o),
      .op_i    (op)
      );

   always @(posedge clk)
   begin
      cycle_cnt++;
      if (cycle_cnt > TIMEOUT)
      begin
         $display("run stopped after %0d cycles without finishing all tests", TIMEOUT);
         $display("Testbench failed");
         $finish;
      end
   end

   // One Galois step per bit, LSB is the bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
      end
      return r;
   endfunction

   function automatic logic [31:0] random_operand();
      logic       s;
      logic [7:0] e;
      s = 1'(take_bits(1));
      e = 8'd100 + 8'(take_bits(6) % 51);   // 100 to 150
      return {s, e, 23'(take_bits(23))};
   endfunction

   task automatic add_entry(input logic [7:0] fmt, input logic [11:0] opc,
                            input logic [31:0] a, input logic [31:0] b,
                            input logic exec, input logic vcc,
                            input logic [31:0] data, input logic vcc_out);
      q_fmt.push_back(fmt);
      q_opc.push_back(opc);
      q_a.push_back(a);
      q_b.push_back(b);
      q_exec.push_back(exec);
      q_vcc.push_back(vcc);
      q_data.push_back(data);
      q_vcc_out.push_back(vcc_out);
   endtask

   task automatic apply_test(input logic [7:0] fmt, input logic [11:0] opc,
                             input logic [31:0] a, input logic [31:0] b,
                             input logic exec, input logic vcc, input logic model,
                             input logic [31:0] data, input logic vcc_out);
      @(negedge clk);
      alu_control_i           = {fmt, 12'h000, opc};
      alu_source1_data_i      = a;
      alu_source2_data_i      = b;
      alu_source_exec_value_i = exec;
      alu_source_vcc_value_i  = vcc;
      use_model               = model;
      exp_data                = data;
      exp_vcc                 = vcc_out;
      alu_start_i             = 1'b1;
      @(negedge clk);
      alu_start_i = 1'b0;
      while (!alu_done_o)
         @(negedge clk);
   endtask

   initial
   begin
      logic [7:0]  fmt;
      logic [11:0] opc;
      logic [31:0] rnd_a;
      logic [31:0] rnd_b;
      logic        rnd_vcc;
      int          asserts;
      rst_n_i                 = 1'b0;
      alu_start_i             = 1'b0;
      alu_control_i           = '0;
      alu_source1_data_i      = '0;
      alu_source2_data_i      = '0;
      alu_source_vcc_value_i  = 1'b0;
      alu_source_exec_value_i = 1'b0;
      use_model               = 1'b0;
      exp_data                = '0;
      exp_vcc                 = 1'b0;
      lfsr                    = SEED;

      // fmt, opcode, src1, src2, exec, vcc in, expected data, expected vcc
      add_entry(8'h40, 12'h003, 32'h3FC00000, 32'h40100000, 1, 1, 32'h40700000, 1);
      add_entry(8'h40, 12'h004, 32'h40400000, 32'h40A00000, 1, 0, 32'hC0000000, 0);
      add_entry(8'h40, 12'h005, 32'h40400000, 32'h40A00000, 1, 1, 32'h40000000, 1);
      add_entry(8'h40, 12'h004, 32'h40400000, 32'h40400000, 1, 0, 32'h00000000, 0);
      add_entry(8'h40, 12'h003, 32'h00000001, 32'h3F800000, 1, 1, 32'h3F800000, 1);
      add_entry(8'h10, 12'h103, 32'h3F800000, 32'h3F800000, 1, 0, 32'h40000000, 0);
      add_entry(8'h10, 12'h104, 32'h40100000, 32'h3FC00000, 1, 1, 32'h3F400000, 1);
      add_entry(8'h10, 12'h105, 32'h40100000, 32'h3FC00000, 1, 0, 32'hBF400000, 0);
      add_entry(8'h40, 12'h008, 32'h3FC00000, 32'h40100000, 1, 1, 32'h40580000, 1);
      add_entry(8'h10, 12'h108, 32'h40400000, 32'hC0A00000, 1, 0, 32'hC1700000, 0);
      add_entry(8'h40, 12'h008, 32'h3FFFFFFF, 32'h3FFFFFFF, 1, 0, 32'h407FFFFE, 0);
      add_entry(8'h40, 12'h008, 32'h1F800000, 32'h1F800000, 1, 1, 32'h00000000, 1);
      add_entry(8'h40, 12'h008, 32'h7E800000, 32'h7E800000, 1, 0, 32'h7F800000, 0);
      add_entry(8'h10, 12'h108, 32'hFE800000, 32'h7E800000, 1, 1, 32'hFF800000, 1);
      add_entry(8'h20, 12'h001, 32'h80000000, 32'h00000000, 1, 1, 32'h00000000, 0);
      add_entry(8'h20, 12'h002, 32'h80000000, 32'h00000000, 1, 0, 32'h00000000, 1);
      add_entry(8'h10, 12'h004, 32'hC0000000, 32'hC0A00000, 1, 0, 32'h00000000, 1);
      add_entry(8'h10, 12'h001, 32'hC0000000, 32'hC0A00000, 1, 1, 32'h00000000, 0);
      add_entry(8'h40, 12'h003, 32'h3F800000, 32'h3F800000, 0, 1, 32'h00000000, 1);
      add_entry(8'h10, 12'h108, 32'h3F800000, 32'h3F800000, 0, 0, 32'h00000000, 0);
      add_entry(8'h40, 12'h0FF, 32'h3F800000, 32'h3F800000, 1, 1, 32'h00000000, 1);
      add_entry(8'h11, 12'h103, 32'h3F800000, 32'h3F800000, 1, 1, 32'h00000000, 1);  // VOP3B

      repeat (16)
         @(negedge clk);
      rst_n_i = 1'b1;

      for (int i = 0; i < q_fmt.size(); i++)
         apply_test(q_fmt[i], q_opc[i], q_a[i], q_b[i], q_exec[i], q_vcc[i], 1'b0,
                    q_data[i], q_vcc_out[i]);

      // Less, equal (-0 against +0) and greater on every condition
      for (int c = 0; c < 16; c++)
      begin
         fmt = c[0] ? simf_alu_pkg::FMT_VOP3A : simf_alu_pkg::FMT_VOPC;
         apply_test(fmt, 12'(c), 32'h3FC00000, 32'h40100000, 1, c[1], 1, '0, 0);
         apply_test(fmt, 12'(c), 32'h80000000, 32'h00000000, 1, c[1], 1, '0, 0);
         apply_test(fmt, 12'(c), 32'hC0000000, 32'hC0A00000, 1, c[1], 1, '0, 0);
      end

      for (int i = 0; i < NUM_RANDOM; i++)
      begin
         opc = 12'(take_bits(2));
         opc = (opc == 12'd3) ? simf_alu_pkg::OPC_MUL : simf_alu_pkg::OPC_ADD + opc;
         fmt = simf_alu_pkg::FMT_VOP2;
         if (take_bits(1))
         begin
            fmt = simf_alu_pkg::FMT_VOP3A;
            opc = opc + simf_alu_pkg::OPC_VOP3_OFS;
         end
         rnd_a   = random_operand();
         rnd_b   = random_operand();
         rnd_vcc = 1'(take_bits(1));
         apply_test(fmt, opc, rnd_a, rnd_b, 1, rnd_vcc, 1, '0, 0);
      end

      repeat (2)
         @(negedge clk);
      asserts = i_simf_alu.i_chk.fail_cnt;
      $display("%0d tests run, %0d passed, %0d failed, %0d assertion failures",
               pass_cnt + fail_cnt, pass_cnt, fail_cnt, asserts);
      if (fail_cnt == 0 && asserts == 0 && pass_cnt == NUM_TESTS)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// ==== simf_alu.f ====
simf_alu_pkg.sv
simf_decode.sv
simf_fp_arith.sv
simf_fp_compare.sv
simf_writeback.sv
simf_alu.sv
simf_alu_chk.sv
simf_alu_monitor.sv
tb_simf_alu.sv
